//--- Bender.yml
package:
  name: vertex_stage

sources:
  - src/gfx_pkg.sv
  - src/fp32_mul.sv
  - src/fp32_add.sv
  - src/delay_pipe.sv
  - src/transform_matrix_regs.sv
  - src/vertex_transform.sv
  - src/vertex_stage_top.sv
  - target: test
    files:
      - test/tb_vertex_stage.sv

//--- sources.f
src/gfx_pkg.sv
src/fp32_mul.sv
src/fp32_add.sv
src/delay_pipe.sv
src/transform_matrix_regs.sv
src/vertex_transform.sv
src/vertex_stage_top.sv
test/tb_vertex_stage.sv

//--- src/delay_pipe.sv
`timescale 1ns/1ns

module delay_pipe #(
  parameter int LATENCY = 1,
  parameter int WIDTH = 8
) (
  input  logic             clk_in,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  logic [WIDTH-1:0] stages [LATENCY];

  always_ff @(posedge clk_in) begin
    stages[0] <= data_in;
    for (int i = 1; i < LATENCY; i++) begin
      stages[i] <= stages[i-1];
    end
  end

  assign data_out = stages[LATENCY-1];

endmodule

//--- src/fp32_add.sv
`timescale 1ns/1ns

module fp32_add import gfx_pkg::*; (
  input  logic  clk_in,
  input  logic  rst_in,
  input  logic  valid_in,
  input  fp32_t a,
  input  fp32_t b,
  output logic  valid_out,
  output fp32_t c
);

  localparam int PAD = ADD_LATENCY - 8;

  logic [ADD_LATENCY-1:0] valid_sr;

  logic       s1_sign_a;
  logic       s1_sign_b;
  logic [7:0] s1_exp_a;
  logic [7:0] s1_exp_b;
  mant_t      s1_man_a;
  mant_t      s1_man_b;
  logic       a_big;

  logic       s2_sign_big;
  logic       s2_sign_small;
  logic [7:0] s2_exp_big;
  logic [7:0] s2_diff;
  mant_t      s2_man_big;
  mant_t      s2_man_small;

  logic [26:0] align_ext;
  logic [26:0] align_shifted;
  logic [26:0] align_mask;
  logic        align_sticky;

  logic        s3_sub;
  logic        s3_sign;
  logic        s3_zero_sign;
  fexp_t       s3_exp;
  logic [26:0] s3_big;
  logic [26:0] s3_small;

  logic        s4_sign;
  logic        s4_zero_sign;
  fexp_t       s4_exp;
  logic [27:0] s4_sum;

  logic        s5_sign;
  logic        s5_zero_sign;
  logic        s5_zero;
  fexp_t       s5_exp;
  logic [27:0] s5_sum;
  logic [4:0]  s5_lzc;

  logic        s6_sign;
  logic        s6_zero_sign;
  logic        s6_zero;
  fexp_t       s6_exp;
  logic [26:0] s6_norm;

  logic [24:0] rnd;

  logic  s7_sign;
  logic  s7_zero_sign;
  logic  s7_zero;
  fexp_t s7_exp;
  mant_t s7_man;

  fp32_t s8_res;
  fp32_t pad_q [PAD];

  function automatic logic [4:0] count_lz(input logic [27:0] v);
    logic [4:0] n;
    logic       found;
    n = 5'd28;
    found = 1'b0;
    for (int i = 27; i >= 0; i--) begin
      if (!found && v[i]) begin
        n = 5'(27 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[ADD_LATENCY-2:0], valid_in};
    end
  end

  assign valid_out = valid_sr[ADD_LATENCY-1];

  always_ff @(posedge clk_in) begin
    s1_sign_a <= a[31];
    s1_sign_b <= b[31];
    s1_exp_a  <= a[30:23];
    s1_exp_b  <= b[30:23];
    s1_man_a  <= {a[30:23] != 8'd0, a[22:0]};
    s1_man_b  <= {b[30:23] != 8'd0, b[22:0]};
  end

  // Larger magnitude goes to the big side
  assign a_big = {s1_exp_a, s1_man_a} >= {s1_exp_b, s1_man_b};

  always_ff @(posedge clk_in) begin
    if (a_big) begin
      s2_sign_big   <= s1_sign_a;
      s2_sign_small <= s1_sign_b;
      s2_exp_big    <= s1_exp_a;
      s2_diff       <= s1_exp_a - s1_exp_b;
      s2_man_big    <= s1_man_a;
      s2_man_small  <= s1_man_b;
    end else begin
      s2_sign_big   <= s1_sign_b;
      s2_sign_small <= s1_sign_a;
      s2_exp_big    <= s1_exp_b;
      s2_diff       <= s1_exp_b - s1_exp_a;
      s2_man_big    <= s1_man_b;
      s2_man_small  <= s1_man_a;
    end
  end

  // Guard, round and sticky below the mantissa
  always_comb begin
    align_ext = {s2_man_small, 3'b000};
    align_mask = '0;
    if (s2_diff >= 8'd27) begin
      align_shifted = '0;
      align_sticky = |align_ext;
    end else begin
      align_shifted = align_ext >> s2_diff;
      align_mask = (27'd1 << s2_diff) - 27'd1;
      align_sticky = |(align_ext & align_mask);
    end
  end

  always_ff @(posedge clk_in) begin
    s3_sub       <= s2_sign_big ^ s2_sign_small;
    s3_sign      <= s2_sign_big;
    s3_zero_sign <= s2_sign_big & s2_sign_small;
    s3_exp       <= fexp_t'({2'b00, s2_exp_big});
    s3_big       <= {s2_man_big, 3'b000};
    s3_small     <= {align_shifted[26:1], align_shifted[0] | align_sticky};
  end

  always_ff @(posedge clk_in) begin
    s4_sign      <= s3_sign;
    s4_zero_sign <= s3_zero_sign;
    s4_exp       <= s3_exp;
    if (s3_sub) begin
      s4_sum <= {1'b0, s3_big} - {1'b0, s3_small};
    end else begin
      s4_sum <= {1'b0, s3_big} + {1'b0, s3_small};
    end
  end

  always_ff @(posedge clk_in) begin
    s5_sign      <= s4_sign;
    s5_zero_sign <= s4_zero_sign;
    s5_zero      <= s4_sum == 28'd0;
    s5_exp       <= s4_exp;
    s5_sum       <= s4_sum;
    s5_lzc       <= count_lz(s4_sum);
  end

  // Carry shifts right once, cancellation shifts left
  always_ff @(posedge clk_in) begin
    s6_sign      <= s5_sign;
    s6_zero_sign <= s5_zero_sign;
    s6_zero      <= s5_zero;
    if (s5_lzc == 5'd0) begin
      s6_norm <= {s5_sum[27:2], s5_sum[1] | s5_sum[0]};
      s6_exp  <= s5_exp + 10'sd1;
    end else begin
      s6_norm <= s5_sum[26:0] << (s5_lzc - 5'd1);
      s6_exp  <= s5_exp - fexp_t'({5'b00000, s5_lzc}) + 10'sd1;
    end
  end

  always_comb begin
    rnd = {1'b0, s6_norm[26:3]} +
          25'(s6_norm[2] & (s6_norm[1] | s6_norm[0] | s6_norm[3]));
  end

  always_ff @(posedge clk_in) begin
    s7_sign      <= s6_sign;
    s7_zero_sign <= s6_zero_sign;
    s7_zero      <= s6_zero;
    if (rnd[24]) begin
      s7_man <= rnd[24:1];
      s7_exp <= s6_exp + 10'sd1;
    end else begin
      s7_man <= rnd[23:0];
      s7_exp <= s6_exp;
    end
  end

  // Exact cancellation gives +0 unless both inputs were negative
  always_ff @(posedge clk_in) begin
    if (s7_zero) begin
      s8_res <= {s7_zero_sign, 31'd0};
    end else if (s7_exp <= 0) begin
      s8_res <= {s7_sign, 31'd0};
    end else if (s7_exp >= 255) begin
      s8_res <= {s7_sign, 8'hff, 23'd0};
    end else begin
      s8_res <= {s7_sign, s7_exp[7:0], s7_man[22:0]};
    end
  end

  always_ff @(posedge clk_in) begin
    pad_q[0] <= s8_res;
    for (int i = 1; i < PAD; i++) begin
      pad_q[i] <= pad_q[i-1];
    end
  end

  assign c = pad_q[PAD-1];

endmodule

//--- src/fp32_mul.sv
`timescale 1ns/1ns

module fp32_mul import gfx_pkg::*; (
  input  logic  clk_in,
  input  logic  rst_in,
  input  logic  valid_in,
  input  fp32_t a,
  input  fp32_t b,
  output logic  valid_out,
  output fp32_t c
);

  // Five working stages, the rest is plain delay
  localparam int PAD = MUL_LATENCY - 5;

  logic [MUL_LATENCY-1:0] valid_sr;

  logic       s1_sign;
  logic       s1_zero;
  logic [7:0] s1_exp_a;
  logic [7:0] s1_exp_b;
  mant_t      s1_man_a;
  mant_t      s1_man_b;

  logic        s2_sign;
  logic        s2_zero;
  fexp_t       s2_exp;
  logic [47:0] s2_prod;

  logic  s3_sign;
  logic  s3_zero;
  logic  s3_guard;
  logic  s3_sticky;
  fexp_t s3_exp;
  mant_t s3_man;

  logic [24:0] rnd;

  logic  s4_sign;
  logic  s4_zero;
  fexp_t s4_exp;
  mant_t s4_man;

  fp32_t s5_res;
  fp32_t pad_q [PAD];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[MUL_LATENCY-2:0], valid_in};
    end
  end

  assign valid_out = valid_sr[MUL_LATENCY-1];

  // Unpack, exponent zero means the operand is zero
  always_ff @(posedge clk_in) begin
    s1_sign  <= a[31] ^ b[31];
    s1_zero  <= (a[30:23] == 8'd0) || (b[30:23] == 8'd0);
    s1_exp_a <= a[30:23];
    s1_exp_b <= b[30:23];
    s1_man_a <= {1'b1, a[22:0]};
    s1_man_b <= {1'b1, b[22:0]};
  end

  always_ff @(posedge clk_in) begin
    s2_sign <= s1_sign;
    s2_zero <= s1_zero;
    s2_exp  <= fexp_t'({2'b00, s1_exp_a}) + fexp_t'({2'b00, s1_exp_b}) - 10'sd127;
    s2_prod <= s1_man_a * s1_man_b;
  end

  // Product lies in [1, 4), pick the top 24 bits
  always_ff @(posedge clk_in) begin
    s3_sign <= s2_sign;
    s3_zero <= s2_zero;
    if (s2_prod[47]) begin
      s3_man    <= s2_prod[47:24];
      s3_guard  <= s2_prod[23];
      s3_sticky <= |s2_prod[22:0];
      s3_exp    <= s2_exp + 10'sd1;
    end else begin
      s3_man    <= s2_prod[46:23];
      s3_guard  <= s2_prod[22];
      s3_sticky <= |s2_prod[21:0];
      s3_exp    <= s2_exp;
    end
  end

  // Round to nearest even
  always_comb begin
    rnd = {1'b0, s3_man} + 25'(s3_guard & (s3_sticky | s3_man[0]));
  end

  always_ff @(posedge clk_in) begin
    s4_sign <= s3_sign;
    s4_zero <= s3_zero;
    if (rnd[24]) begin
      s4_man <= rnd[24:1];
      s4_exp <= s3_exp + 10'sd1;
    end else begin
      s4_man <= rnd[23:0];
      s4_exp <= s3_exp;
    end
  end

  // Underflow flushes to a signed zero
  always_ff @(posedge clk_in) begin
    if (s4_zero || s4_exp <= 0) begin
      s5_res <= {s4_sign, 31'd0};
    end else if (s4_exp >= 255) begin
      s5_res <= {s4_sign, 8'hff, 23'd0};
    end else begin
      s5_res <= {s4_sign, s4_exp[7:0], s4_man[22:0]};
    end
  end

  always_ff @(posedge clk_in) begin
    pad_q[0] <= s5_res;
    for (int i = 1; i < PAD; i++) begin
      pad_q[i] <= pad_q[i-1];
    end
  end

  assign c = pad_q[PAD-1];

endmodule

//--- src/gfx_pkg.sv
package gfx_pkg;

  typedef logic [31:0] fp32_t;
  typedef logic [11:0] attr_t;

  // Mantissa with hidden bit, and a biased exponent with headroom for
  // overflow and underflow checks
  typedef logic [23:0] mant_t;
  typedef logic signed [9:0] fexp_t;

  typedef struct packed {
    fp32_t x;
    fp32_t y;
    fp32_t z;
  } vec3_t;

  typedef struct packed {
    fp32_t x;
    fp32_t y;
    fp32_t z;
    fp32_t w;
  } vec4_t;

  typedef struct packed {
    vec3_t position;
    attr_t normal;
    attr_t material;
  } vertex_in_t;

  typedef struct packed {
    vec4_t position;
    attr_t normal;
    attr_t material;
  } vertex_out_t;

  localparam fp32_t FP_ONE = 32'h3f80_0000;

  localparam int MUL_LATENCY = 7;
  localparam int ADD_LATENCY = 9;
  localparam int TRANSFORM_LATENCY = MUL_LATENCY + 2 * ADD_LATENCY;

  // Lane 0 is x, lane 3 is w
  function automatic fp32_t vec4_lane(input vec4_t v, input int unsigned idx);
    case (idx)
      0: return v.x;
      1: return v.y;
      2: return v.z;
      default: return v.w;
    endcase
  endfunction

endpackage

//--- src/transform_matrix_regs.sv
`timescale 1ns/1ns

module transform_matrix_regs import gfx_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        col_set,
  input  vec4_t       col,
  output vec4_t [3:0] cols
);

  logic [1:0] col_ptr;

  // Identity after reset, one column per strobe after that
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      col_ptr <= 2'd0;
      cols[0] <= '{x: FP_ONE, y: '0, z: '0, w: '0};
      cols[1] <= '{x: '0, y: FP_ONE, z: '0, w: '0};
      cols[2] <= '{x: '0, y: '0, z: FP_ONE, w: '0};
      cols[3] <= '{x: '0, y: '0, z: '0, w: FP_ONE};
    end else if (col_set) begin
      cols[col_ptr] <= col;
      // Wraps from 3 to 0
      col_ptr <= col_ptr + 2'd1;
    end
  end

endmodule

//--- src/vertex_stage_top.sv
`timescale 1ns/1ns

module vertex_stage_top import gfx_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        col_set_in,
  input  vec4_t       col_in,
  input  logic        valid_in,
  input  vertex_in_t  vertex_in,
  output logic        valid_out,
  output vertex_out_t vertex_out
);

  vec4_t [3:0] cols;
  vec4_t       position_out;
  logic [23:0] attr_out;

  transform_matrix_regs i_transform_matrix_regs (
    .clk_in,
    .rst_in,
    .col_set (col_set_in),
    .col     (col_in),
    .cols    (cols)
  );

  vertex_transform i_vertex_transform (
    .clk_in,
    .rst_in,
    .valid_in,
    .position     (vertex_in.position),
    .cols         (cols),
    .valid_out    (valid_out),
    .position_out (position_out)
  );

  // Normal in the upper half, material in the lower
  delay_pipe #(
    .LATENCY (TRANSFORM_LATENCY),
    .WIDTH   (24)
  ) i_attr_delay (
    .clk_in,
    .data_in  ({vertex_in.normal, vertex_in.material}),
    .data_out (attr_out)
  );

  assign vertex_out = '{
    position: position_out,
    normal:   attr_out[23:12],
    material: attr_out[11:0]
  };

endmodule

//--- src/vertex_transform.sv
`timescale 1ns/1ns

module vertex_transform import gfx_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        valid_in,
  input  vec3_t       position,
  input  vec4_t [3:0] cols,
  output logic        valid_out,
  output vec4_t       position_out
);

  fp32_t      comp [4];
  fp32_t      lane_out [4];
  logic [3:0] lane_valid;

  assign comp[0] = position.x;
  assign comp[1] = position.y;
  assign comp[2] = position.z;
  assign comp[3] = FP_ONE;

  // Lane i is the dot product of the vertex with row i of the matrix
  for (genvar i = 0; i < 4; i++) begin : g_lane
    fp32_t      prod [4];
    logic [3:0] prod_valid;
    fp32_t      left_sum;
    fp32_t      right_sum;
    logic       left_valid;
    logic       right_valid;

    for (genvar j = 0; j < 4; j++) begin : g_mul
      fp32_mul i_fp32_mul (
        .clk_in,
        .rst_in,
        .valid_in,
        .a         (comp[j]),
        .b         (vec4_lane(cols[j], i)),
        .valid_out (prod_valid[j]),
        .c         (prod[j])
      );
    end

    // x and y terms
    fp32_add i_add_left (
      .clk_in,
      .rst_in,
      .valid_in  (prod_valid[0] & prod_valid[1]),
      .a         (prod[0]),
      .b         (prod[1]),
      .valid_out (left_valid),
      .c         (left_sum)
    );

    // z and w terms
    fp32_add i_add_right (
      .clk_in,
      .rst_in,
      .valid_in  (prod_valid[2] & prod_valid[3]),
      .a         (prod[2]),
      .b         (prod[3]),
      .valid_out (right_valid),
      .c         (right_sum)
    );

    fp32_add i_add_final (
      .clk_in,
      .rst_in,
      .valid_in  (left_valid & right_valid),
      .a         (left_sum),
      .b         (right_sum),
      .valid_out (lane_valid[i]),
      .c         (lane_out[i])
    );
  end

  // All lanes have the same latency
  assign valid_out = lane_valid[0];

  assign position_out = '{
    x: lane_out[0],
    y: lane_out[1],
    z: lane_out[2],
    w: lane_out[3]
  };

endmodule

//--- test/tb_vertex_stage.sv
`timescale 1ns/1ns

module tb_vertex_stage
  import gfx_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int OUT_LATENCY = 25;

  typedef struct packed {
    logic [7:0]  kind;
    logic [31:0] count;
    vec4_t       col;
    vertex_in_t  vtx;
  } cmd_t;

  typedef struct packed {
    logic [31:0] test;
    vertex_out_t vtx;
  } expect_t;

  logic        clk_in = 1'b0;
  logic        rst_in;
  logic        col_set_in;
  vec4_t       col_in;
  logic        valid_in;
  vertex_in_t  vertex_in;
  logic        valid_out;
  vertex_out_t vertex_out;

  cmd_t    cmds [$];
  expect_t exp_q [$];
  string   test_names [$];
  int      test_errs [$];
  int      issue_q [$];

  expect_t exp_e;
  int      cur_test;
  int      issue_cycle;
  int      cycle_count = 0;
  int      stim_cycles = 0;
  int      error_count = 0;
  int      other_errors = 0;
  int      tests_passed = 0;
  int      tests_failed = 0;
  bit      parse_done = 1'b0;
  bit      file_error = 1'b0;

  vertex_stage_top i_vertex_stage_top (
    .clk_in,
    .rst_in,
    .col_set_in,
    .col_in,
    .valid_in,
    .vertex_in,
    .valid_out,
    .vertex_out
  );

  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  always @(posedge clk_in) cycle_count++;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("ERR t=%0t %s got=%h expected=%h", $time, name, got, expected);
      error_count++;
      test_errs[cur_test]++;
    end
  endtask

  task automatic report_test(input int id);
    if (test_errs[id] == 0) begin
      tests_passed++;
      $display("test %s: ok", test_names[id]);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", test_names[id], test_errs[id]);
    end
  endtask

  // Every C, V and G line becomes a command, every E line an expected vertex
  task automatic load_golden();
    int          fd;
    int          code;
    int          cur;
    string       tok;
    string       name;
    logic [31:0] v [6];
    cmd_t        cmd;
    expect_t     e;
    reg [8*256-1:0] line_buf;
    cur = 0;
    fd = $fopen("test/vertex_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/vertex_golden.txt");
      file_error = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %s", tok);
      if (code != 1) break;
      cmd = '0;
      if (tok.substr(0, 0) == "#") begin
        code = $fgets(line_buf, fd);
      end else if (tok == "T") begin
        code = $fscanf(fd, " %s", name);
        test_names.push_back(name);
        test_errs.push_back(0);
        cur = test_names.size() - 1;
      end else if (tok == "C") begin
        code = $fscanf(fd, " %h %h %h %h", v[0], v[1], v[2], v[3]);
        cmd.kind = "C";
        cmd.col = {v[0], v[1], v[2], v[3]};
        cmds.push_back(cmd);
        stim_cycles++;
      end else if (tok == "V") begin
        code = $fscanf(fd, " %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4]);
        cmd.kind = "V";
        cmd.vtx = {v[0], v[1], v[2], v[3][11:0], v[4][11:0]};
        cmds.push_back(cmd);
        stim_cycles++;
      end else if (tok == "E") begin
        code = $fscanf(fd, " %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
        e.test = cur;
        e.vtx = {v[0], v[1], v[2], v[3], v[4][11:0], v[5][11:0]};
        exp_q.push_back(e);
      end else if (tok == "G") begin
        code = $fscanf(fd, " %d", v[0]);
        cmd.kind = "G";
        cmd.count = v[0];
        cmds.push_back(cmd);
        // A zero count is a random gap of up to three cycles
        stim_cycles += (v[0] == 0) ? 3 : v[0];
      end else begin
        $display("Unknown line kind '%s' in the golden file", tok);
        file_error = 1'b1;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_command(input cmd_t cmd);
    int gap;
    gap = cmd.count;
    if (cmd.kind == "G") begin
      if (gap == 0) gap = $urandom % 3 + 1;
      repeat (gap) begin
        @(posedge clk_in);
        #1;
        col_set_in = 1'b0;
        valid_in = 1'b0;
      end
    end else begin
      @(posedge clk_in);
      #1;
      col_set_in = (cmd.kind == "C");
      col_in = cmd.col;
      valid_in = (cmd.kind == "V");
      vertex_in = cmd.vtx;
      if (cmd.kind == "V") issue_q.push_back(cycle_count);
    end
  endtask

  initial begin
    int wait_cycles;
    rst_in = 1'b1;
    col_set_in = 1'b0;
    col_in = '0;
    valid_in = 1'b0;
    vertex_in = '0;
    void'($urandom(25170));
    load_golden();
    parse_done = 1'b1;
    if (!file_error) begin
      repeat (3) @(posedge clk_in);
      #1;
      rst_in = 1'b0;
      foreach (cmds[i]) run_command(cmds[i]);
      @(posedge clk_in);
      #1;
      col_set_in = 1'b0;
      valid_in = 1'b0;
      wait_cycles = 0;
      while (exp_q.size() != 0 && wait_cycles < TRANSFORM_LATENCY + 10) begin
        @(posedge clk_in);
        wait_cycles++;
      end
      if (exp_q.size() != 0) begin
        $display("%0d expected vertices never appeared at the output", exp_q.size());
        other_errors++;
      end
      // Catch any surplus output pulses
      repeat (5) @(posedge clk_in);
    end
    $display("Tests passed: %0d  failed: %0d  mismatches: %0d  other errors: %0d",
             tests_passed, tests_failed, error_count, other_errors);
    if (tests_failed == 0 && error_count == 0 && other_errors == 0 && !file_error) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Outputs settle after the rising edge, so compare on the falling edge
  always @(negedge clk_in) begin
    if (!rst_in && valid_out) begin
      if (exp_q.size() == 0) begin
        $display("Output vertex at %0t arrived with no expected vertex left", $time);
        other_errors++;
      end else begin
        exp_e = exp_q.pop_front();
        cur_test = exp_e.test;
        // Output pulse repeats the input pattern a fixed number of cycles later
        if (issue_q.size() == 0) begin
          $display("Output vertex at %0t arrived before its input vertex", $time);
          other_errors++;
        end else begin
          issue_cycle = issue_q.pop_front();
          check_value("valid_out latency", cycle_count - issue_cycle, OUT_LATENCY);
        end
        check_value("position.x", vertex_out.position.x, exp_e.vtx.position.x);
        check_value("position.y", vertex_out.position.y, exp_e.vtx.position.y);
        check_value("position.z", vertex_out.position.z, exp_e.vtx.position.z);
        check_value("position.w", vertex_out.position.w, exp_e.vtx.position.w);
        check_value("normal", 32'(vertex_out.normal), 32'(exp_e.vtx.normal));
        check_value("material", 32'(vertex_out.material), 32'(exp_e.vtx.material));
        if (exp_q.size() == 0 || exp_q[0].test != cur_test) report_test(cur_test);
      end
    end
  end

  initial begin
    wait (parse_done);
    #((stim_cycles + TRANSFORM_LATENCY + 50) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles",
             stim_cycles + TRANSFORM_LATENCY + 50);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- test/vertex_golden.txt
# T name | C x y z w (one matrix column) | V x y z normal material
# E x y z w normal material (expected output) | G idle cycles, 0 for a random gap
T identity
V 3f800000 40000000 40400000 001 002
E 3f800000 40000000 40400000 3f800000 001 002
G 0
V c0200000 3f000000 40800000 abc 123
E c0200000 3f000000 40800000 3f800000 abc 123
T matrix_load
C 40000000 00000000 00000000 00000000
C 00000000 40400000 00000000 00000000
C 00000000 00000000 3f000000 00000000
C 41200000 c0800000 3f800000 3f800000
V 3f800000 40000000 40800000 100 0ff
E 41400000 40000000 40400000 3f800000 100 0ff
G 0
V bf800000 3f000000 41000000 7ff 800
E 41000000 c0200000 40a00000 3f800000 7ff 800
G 2
T pointer_wrap
C 3f800000 00000000 00000000 00000000
V 40400000 3f800000 40000000 5a5 a5a
E 41500000 bf800000 40000000 3f800000 5a5 a5a
G 0
T streaming
V 3f800000 3f800000 3f800000 011 022
E 41300000 bf800000 3fc00000 3f800000 011 022
V 40000000 40000000 40000000 033 044
E 41400000 40000000 40000000 3f800000 033 044
V 40800000 00000000 00000000 055 066
E 41600000 c0800000 3f800000 3f800000 055 066
V 00000000 00000000 40800000 077 088
E 41200000 c0800000 40400000 3f800000 077 088
T midstream
V 3f800000 40000000 40400000 101 202
E 41300000 40000000 40200000 3f800000 101 202
C 00000000 bf800000 00000000 00000000
V 3f800000 40000000 40400000 303 404
E 41300000 c0c00000 40200000 3f800000 303 404
G 0
T arith_edges
C 00000000 00000000 3f800000 00000000
C 00000000 00000000 00000000 3f800000
C 3f800000 3f800000 00000000 00000000
C 3f800000 bf800000 00000000 00000000
V 00000000 00000000 00000000 111 222
E 00000000 00000000 00000000 3f800000 111 222
V 40400000 40400000 c0000000 333 444
E 40c00000 00000000 c0000000 3f800000 333 444
G 0
V bfc00000 c0200000 c0800000 555 666
E c0800000 3f800000 c0800000 3f800000 555 666
V 00c00000 00800000 3f800000 777 888
E 01200000 00000000 3f800000 3f800000 777 888
V 3f800000 33800000 00000000 999 aaa
E 3f800000 3f7fffff 00000000 3f800000 999 aaa
V 3f800000 33c00000 00000000 bbb ccc
E 3f800001 3f7ffffe 00000000 3f800000 bbb ccc
